// ==== hdl/pe_config.svh ====
// Sizes of one processing element; PE_NUM_OUT must equal
// PE_NUM_SECT * PE_SECT_SIZE - PE_TAPS + 1
`ifndef PE_CONFIG_SVH
`define PE_CONFIG_SVH

// Operand and result widths, all signed
`define PE_IFDATA_W     8
`define PE_WDATA_W      8
`define PE_PROD_W       16
// Partial sums wrap modulo 2**PE_PSUM_W
`define PE_PSUM_W       20

// Filter geometry
`define PE_TAPS         3
`define PE_NUM_FILTERS  4

// Input row split into packets, one packet per section
`define PE_SECT_SIZE    4
`define PE_NUM_SECT     3
`define PE_NUM_OUT      10

`endif

// ==== hdl/pe_pkg.sv ====
// Types shared by the processing element and its testbench
`default_nettype none

package pe_pkg;

    `include "pe_config.svh"

    // Operating stage driven by the array controller
    typedef enum logic [1:0] {
        STAGE_IDLE,
        STAGE_LOAD_FILTER,
        STAGE_CONV
    } op_stage_e;

    // Plain two's-complement data
    typedef logic signed [`PE_IFDATA_W-1:0] ifdata_t;
    typedef logic signed [`PE_WDATA_W-1:0]  weight_t;
    typedef logic signed [`PE_PROD_W-1:0]   prod_t;
    typedef logic signed [`PE_PSUM_W-1:0]   psum_t;

    // Indices into the filter rows
    typedef logic [1:0] filter_idx_t;
    typedef logic [1:0] tap_idx_t;

    // One input packet, element 0 is the lowest sample
    typedef ifdata_t [`PE_SECT_SIZE-1:0] ifmap_pkt_t;

endpackage

`default_nettype wire

// ==== hdl/mac_if.sv ====
// One issued MAC operation; operands are valid in the issue cycle only
`timescale 1ns/1ns
`default_nettype none

interface mac_if import pe_pkg::*; ();

    // Strobe, one operation per cycle at most
    logic        issue;
    // Operands, read combinationally from the scratchpads
    ifdata_t     ifdata;
    weight_t     weight;
    // Tags that ride along the pipeline
    filter_idx_t filter;
    logic        last_tap;

    // Controller side
    // Operand data is driven by the scratchpad outputs in the top level
    modport master (
        output issue,
        output filter,
        output last_tap
    );

    // Pipeline side
    modport slave (
        input issue,
        input ifdata,
        input weight,
        input filter,
        input last_tap
    );

endinterface

`default_nettype wire

// ==== hdl/pe_ctrl.sv ====
// Issue order is filter fastest, then tap, then position; stride 1
// slots_empty comes from the output buffer for done detection
`timescale 1ns/1ns
`default_nettype none
`include "pe_config.svh"

module pe_ctrl import pe_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  op_stage_e   stage,
    input  logic        conv_continue,
    input  logic        sect_data_ok,
    input  logic        slot_busy,
    input  logic        slots_empty,
    output logic [3:0]  read_addr,
    output tap_idx_t    tap_sel,
    output filter_idx_t filt_sel,
    output logic        freeze,
    mac_if.master       mac,
    output logic        conv_done
);

    localparam int ROW_LEN = `PE_NUM_SECT * `PE_SECT_SIZE;

    filter_idx_t filt_cnt;
    tap_idx_t    tap_cnt;
    logic [3:0]  pos_cnt;
    logic [3:0]  win_start;
    logic [3:0]  addr_sum;
    logic        all_issued;
    // Shadow of the three pipeline stages
    logic [2:0]  inflight;
    logic        issue;
    logic        last_filt;
    logic        last_tap;

    ////////////////////////////////////////////////////////////////////
    // Issue decision
    ////////////////////////////////////////////////////////////////////

    // Back-pressure from the output buffer stops everything
    assign freeze = slot_busy;

    // Hold off on missing data, after the last position, and on restart
    assign issue = (stage == STAGE_CONV) && !conv_continue && !all_issued
                   && sect_data_ok && !freeze;

    assign last_filt = (filt_cnt == filter_idx_t'(`PE_NUM_FILTERS - 1));
    assign last_tap  = (tap_cnt == tap_idx_t'(`PE_TAPS - 1));

    // Window start plus tap, wrapped at the row length
    assign addr_sum  = win_start + 4'(tap_cnt);
    assign read_addr = (addr_sum >= 4'(ROW_LEN)) ? addr_sum - 4'(ROW_LEN) : addr_sum;

    assign tap_sel  = tap_cnt;
    assign filt_sel = filt_cnt;

    assign mac.issue    = issue;
    assign mac.filter   = filt_cnt;
    assign mac.last_tap = last_tap;

    ////////////////////////////////////////////////////////////////////
    // Counters
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n || conv_continue) begin
            filt_cnt   <= '0;
            tap_cnt    <= '0;
            pos_cnt    <= '0;
            win_start  <= '0;
            all_issued <= 1'b0;
        end else if (issue) begin
            filt_cnt <= filt_cnt + 1'b1;
            if (last_filt) begin
                if (last_tap) begin
                    // Position complete, slide the window by one sample
                    tap_cnt   <= '0;
                    pos_cnt   <= pos_cnt + 1'b1;
                    win_start <= (win_start == 4'(ROW_LEN - 1)) ? '0 : win_start + 1'b1;
                    if (pos_cnt == 4'(`PE_NUM_OUT - 1))
                        all_issued <= 1'b1;
                end else begin
                    tap_cnt <= tap_cnt + 1'b1;
                end
            end
        end
    end

    // Pipeline occupancy, frozen together with the MAC stages
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            inflight <= '0;
        end else if (!freeze) begin
            inflight <= {inflight[1:0], issue};
        end
    end

    // Done once everything is written back and handed downstream
    always_ff @(posedge clk) begin
        if (!rst_n || conv_continue) begin
            conv_done <= 1'b0;
        end else if (all_issued && inflight == '0 && slots_empty) begin
            conv_done <= 1'b1;
        end
    end

    // No operation slips into a frozen pipeline
    assert property (@(posedge clk) disable iff (!rst_n) !(mac.issue && freeze));

    // A finished round stays quiet until restarted
    assert property (@(posedge clk) disable iff (!rst_n) conv_done |-> !mac.issue);

endmodule

`default_nettype wire

// ==== hdl/filter_spad.sv ====
// Weights shift into a row, so tap 0 holds the most recently loaded one
`timescale 1ns/1ns
`default_nettype none
`include "pe_config.svh"

module filter_spad import pe_pkg::*; #(
    parameter logic [3:0] pe_idx = 4'd0
) (
    input  logic        clk,
    input  logic        rst_n,
    input  op_stage_e   stage,
    input  logic        filter_valid,
    input  logic [3:0]  filter_idx,
    input  filter_idx_t filter_sel,
    input  weight_t     filter_data,
    input  tap_idx_t    tap_sel,
    input  filter_idx_t filt_sel,
    output weight_t     weight
);

    // One row per filter
    weight_t rows [`PE_NUM_FILTERS][`PE_TAPS];
    logic    load;

    // Only our own weights, and only in the load stage
    assign load = filter_valid && (stage == STAGE_LOAD_FILTER) && (filter_idx == pe_idx);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rows <= '{default: '0};
        end else if (load) begin
            // Older taps move up by one
            for (int k = `PE_TAPS - 1; k > 0; k--)
                rows[filter_sel][k] <= rows[filter_sel][k-1];
            rows[filter_sel][0] <= filter_data;
        end
    end

    assign weight = rows[filt_sel][tap_sel];

endmodule

`default_nettype wire

// ==== hdl/ifmap_spad.sv ====
// Sections are freed when the read address shows a new window start;
// a packet that finds no free section is dropped and flags error
`timescale 1ns/1ns
`default_nettype none
`include "pe_config.svh"

module ifmap_spad import pe_pkg::*; #(
    parameter logic [3:0] pe_idx = 4'd0
) (
    input  logic       clk,
    input  logic       rst_n,
    input  op_stage_e  stage,
    input  logic       conv_continue,
    input  logic       ifmap_valid,
    input  logic [3:0] ifmap_idx,
    input  ifmap_pkt_t ifmap_data,
    input  logic [3:0] read_addr,
    output ifdata_t    ifdata,
    output logic       sect_data_ok,
    output logic       full,
    output logic       error
);

    localparam int ROW_LEN = `PE_NUM_SECT * `PE_SECT_SIZE;

    ifdata_t                  ram [ROW_LEN];
    logic [`PE_NUM_SECT-1:0]  sect_valid;
    logic [`PE_NUM_SECT-1:0]  valid_after_free;
    logic [`PE_NUM_SECT-1:0]  free_mask;
    logic [1:0]               wr_sect;
    logic [1:0]               rd_sect;
    logic [3:0]               prev_addr;
    logic                     accept;
    logic                     write;

    // Packet addressed to this element during convolution
    assign accept = ifmap_valid && (stage == STAGE_CONV) && (ifmap_idx == pe_idx);

    assign rd_sect = 2'(read_addr / `PE_SECT_SIZE);

    ////////////////////////////////////////////////////////////////////
    // Section release
    ////////////////////////////////////////////////////////////////////

    // Read address stepping back by one onto a section boundary means
    // the window start entered that section, so the one before is done
    always_comb begin
        free_mask = '0;
        if ((read_addr % `PE_SECT_SIZE) == 0 && prev_addr == read_addr + 4'd1) begin
            if (rd_sect == 2'd0)
                free_mask[`PE_NUM_SECT-1] = 1'b1;
            else
                free_mask[rd_sect-1'b1] = 1'b1;
        end
    end

    assign valid_after_free = sect_valid & ~free_mask;

    // Rotation target must be free, else the packet is lost
    assign write = accept && !valid_after_free[wr_sect];
    assign error = accept && valid_after_free[wr_sect];

    always_ff @(posedge clk) begin
        if (!rst_n || conv_continue) begin
            sect_valid <= '0;
            wr_sect    <= '0;
        end else begin
            sect_valid <= valid_after_free;
            if (write) begin
                sect_valid[wr_sect] <= 1'b1;
                wr_sect <= (wr_sect == 2'(`PE_NUM_SECT - 1)) ? 2'd0 : wr_sect + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            prev_addr <= '0;
        end else begin
            prev_addr <= read_addr;
        end
    end

    // Sample storage
    always_ff @(posedge clk) begin
        if (write) begin
            for (int i = 0; i < `PE_SECT_SIZE; i++)
                ram[int'(wr_sect) * `PE_SECT_SIZE + i] <= ifmap_data[i];
        end
    end

    assign ifdata       = ram[read_addr];
    assign sect_data_ok = sect_valid[rd_sect];
    assign full         = &sect_valid;

    // Rotation and release order keep the write target the oldest section
    assert property (@(posedge clk) disable iff (!rst_n) error |-> full);

endmodule

`default_nettype wire

// ==== hdl/mac_pipe.sv ====
// Three stages: operands, product, sum; all stages hold under freeze
`timescale 1ns/1ns
`default_nettype none
`include "pe_config.svh"

module mac_pipe import pe_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        freeze,
    mac_if.slave        mac,
    output logic        result_valid,
    output filter_idx_t result_filter,
    output psum_t       result_data,
    output logic        wb_last
);

    // Operand stage
    logic        op_valid;
    filter_idx_t op_filter;
    logic        op_last;
    ifdata_t     op_a;
    weight_t     op_b;
    // Product stage
    logic        mul_valid;
    filter_idx_t mul_filter;
    logic        mul_last;
    prod_t       mul_prod;
    // Running sum per filter
    psum_t       run_sum [`PE_NUM_FILTERS];
    psum_t       sum_next;

    // Tags and valids
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            op_valid     <= 1'b0;
            mul_valid    <= 1'b0;
            result_valid <= 1'b0;
        end else if (!freeze) begin
            op_valid     <= mac.issue;
            mul_valid    <= op_valid;
            result_valid <= mul_valid;
        end
    end

    // Payload moves with the valids
    always_ff @(posedge clk) begin
        if (!freeze) begin
            op_a          <= mac.ifdata;
            op_b          <= mac.weight;
            op_filter     <= mac.filter;
            op_last       <= mac.last_tap;
            mul_prod      <= op_a * op_b;
            mul_filter    <= op_filter;
            mul_last      <= op_last;
            result_data   <= sum_next;
            result_filter <= mul_filter;
            wb_last       <= mul_last;
        end
    end

    // Sign-extended product onto the filter's running sum
    assign sum_next = run_sum[mul_filter] + psum_t'(mul_prod);

    // Last tap restarts the sum for the next position
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            run_sum <= '{default: '0};
        end else if (!freeze && mul_valid) begin
            run_sum[mul_filter] <= mul_last ? '0 : sum_next;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/psum_out_buf.sv ====
// One slot per filter; a slot frees only when its partial sum is
// accepted, and a new finished result waits on a busy slot
`timescale 1ns/1ns
`default_nettype none
`include "pe_config.svh"

module psum_out_buf import pe_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        result_valid,
    input  filter_idx_t result_filter,
    input  psum_t       result_data,
    input  logic        wb_last,
    output logic        slot_busy,
    output logic        slots_empty,
    input  logic        psum_in_valid,
    input  filter_idx_t psum_in_filter,
    input  psum_t       psum_in_data,
    output logic        psum_in_ack,
    output logic        psum_out_valid,
    output filter_idx_t psum_out_filter,
    output psum_t       psum_out_data,
    input  logic        psum_out_ack
);

    psum_t                      slot [`PE_NUM_FILTERS];
    logic [`PE_NUM_FILTERS-1:0] ready;
    logic [`PE_NUM_FILTERS-1:0] ready_freed;
    logic                       out_free;
    logic                       finish;

    // Output register empty now or emptied this cycle
    assign out_free = !psum_out_valid || psum_out_ack;

    // Accept upstream only with a finished local sum to add
    assign psum_in_ack = psum_in_valid && out_free && ready[psum_in_filter];

    // Slot released by this cycle's acceptance can be refilled at once
    always_comb begin
        ready_freed = ready;
        if (psum_in_ack)
            ready_freed[psum_in_filter] = 1'b0;
    end

    assign finish      = result_valid && wb_last;
    assign slot_busy   = finish && ready_freed[result_filter];
    assign slots_empty = (ready == '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ready <= '0;
        end else begin
            ready <= ready_freed;
            if (finish && !slot_busy)
                ready[result_filter] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (finish && !slot_busy)
            slot[result_filter] <= result_data;
    end

    ////////////////////////////////////////////////////////////////////
    // Vertical accumulation and output register
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            psum_out_valid <= 1'b0;
        end else if (psum_in_ack) begin
            psum_out_valid <= 1'b1;
        end else if (psum_out_ack) begin
            psum_out_valid <= 1'b0;
        end
    end

    // Sum wraps at the partial-sum width
    always_ff @(posedge clk) begin
        if (psum_in_ack) begin
            psum_out_data   <= slot[psum_in_filter] + psum_in_data;
            psum_out_filter <= psum_in_filter;
        end
    end

    // Held data stays put until the consumer takes it
    assert property (@(posedge clk) disable iff (!rst_n)
        psum_out_valid && !psum_out_ack |=> $stable(psum_out_data));

endmodule

`default_nettype wire

// ==== hdl/pe_top.sv ====
// Processing element top; pe_idx selects both the weights and the
// ifmap packets this element takes
`timescale 1ns/1ns
`default_nettype none

module pe_top import pe_pkg::*; #(
    parameter logic [3:0] pe_idx = 4'd0
) (
    input  logic        clk,
    input  logic        rst_n,
    input  op_stage_e   stage,
    // Filter load
    input  logic        filter_valid,
    input  filter_idx_t filter_sel,
    input  logic [3:0]  filter_idx,
    input  weight_t     filter_data,
    // Input row packets
    input  logic        ifmap_valid,
    input  logic [3:0]  ifmap_idx,
    input  ifmap_pkt_t  ifmap_data,
    // Partial sums from the neighbour
    input  logic        psum_in_valid,
    input  filter_idx_t psum_in_filter,
    input  psum_t       psum_in_data,
    output logic        psum_in_ack,
    // Partial sums passed on
    output logic        psum_out_valid,
    output filter_idx_t psum_out_filter,
    output psum_t       psum_out_data,
    input  logic        psum_out_ack,
    // Round control and status
    input  logic        conv_continue,
    output logic        conv_done,
    output logic        full,
    output logic        error
);

    logic [3:0]  read_addr;
    logic        sect_data_ok;
    tap_idx_t    tap_sel;
    filter_idx_t filt_sel;
    logic        freeze;
    logic        slot_busy;
    logic        slots_empty;
    logic        result_valid;
    filter_idx_t result_filter;
    psum_t       result_data;
    logic        wb_last;

    mac_if mac_bus ();

    pe_ctrl u_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .stage         (stage),
        .conv_continue (conv_continue),
        .sect_data_ok  (sect_data_ok),
        .slot_busy     (slot_busy),
        .slots_empty   (slots_empty),
        .read_addr     (read_addr),
        .tap_sel       (tap_sel),
        .filt_sel      (filt_sel),
        .freeze        (freeze),
        .mac           (mac_bus.master),
        .conv_done     (conv_done)
    );

    // Weight operand goes straight onto the MAC bus
    filter_spad #(.pe_idx(pe_idx)) u_filt (
        .clk          (clk),
        .rst_n        (rst_n),
        .stage        (stage),
        .filter_valid (filter_valid),
        .filter_idx   (filter_idx),
        .filter_sel   (filter_sel),
        .filter_data  (filter_data),
        .tap_sel      (tap_sel),
        .filt_sel     (filt_sel),
        .weight       (mac_bus.weight)
    );

    // Input operand likewise
    ifmap_spad #(.pe_idx(pe_idx)) u_ifmap (
        .clk           (clk),
        .rst_n         (rst_n),
        .stage         (stage),
        .conv_continue (conv_continue),
        .ifmap_valid   (ifmap_valid),
        .ifmap_idx     (ifmap_idx),
        .ifmap_data    (ifmap_data),
        .read_addr     (read_addr),
        .ifdata        (mac_bus.ifdata),
        .sect_data_ok  (sect_data_ok),
        .full          (full),
        .error         (error)
    );

    mac_pipe u_mac (
        .clk           (clk),
        .rst_n         (rst_n),
        .freeze        (freeze),
        .mac           (mac_bus.slave),
        .result_valid  (result_valid),
        .result_filter (result_filter),
        .result_data   (result_data),
        .wb_last       (wb_last)
    );

    psum_out_buf u_obuf (
        .clk             (clk),
        .rst_n           (rst_n),
        .result_valid    (result_valid),
        .result_filter   (result_filter),
        .result_data     (result_data),
        .wb_last         (wb_last),
        .slot_busy       (slot_busy),
        .slots_empty     (slots_empty),
        .psum_in_valid   (psum_in_valid),
        .psum_in_filter  (psum_in_filter),
        .psum_in_data    (psum_in_data),
        .psum_in_ack     (psum_in_ack),
        .psum_out_valid  (psum_out_valid),
        .psum_out_filter (psum_out_filter),
        .psum_out_data   (psum_out_data),
        .psum_out_ack    (psum_out_ack)
    );

endmodule

`default_nettype wire

// ==== bench/clk_gen.sv ====
// Free-running clock; reset is synchronous, active low, held for rst_cycles edges
`timescale 1ns/1ns
`default_nettype none

module clk_gen #(
    parameter int period     = 100,
    parameter int rst_cycles = 3
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    // Released on a rising edge so the first active cycle is a full one
    initial begin
        rst_n = 1'b0;
        repeat (rst_cycles) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

`default_nettype wire

// ==== bench/pe_tb.sv ====
// Testbench for pe_top with pe_idx 5; inputs change on rising edges,
// outputs are sampled on falling edges
`timescale 1ns/1ns
`default_nettype none
`include "pe_config.svh"

module pe_tb import pe_pkg::*; ();

    localparam logic [3:0] pe_index      = 4'd5;
    localparam int         num_tests     = 5;
    localparam int         cycles_per_test = 20000;
    localparam int         round_outputs = `PE_NUM_OUT * `PE_NUM_FILTERS;
    localparam int         row_len       = `PE_NUM_SECT * `PE_SECT_SIZE;

    logic        clk;
    logic        rst_n;
    op_stage_e   stage;
    logic        filter_valid;
    filter_idx_t filter_sel;
    logic [3:0]  filter_idx;
    weight_t     filter_data;
    logic        ifmap_valid;
    logic [3:0]  ifmap_idx;
    ifmap_pkt_t  ifmap_data;
    logic        psum_in_valid;
    filter_idx_t psum_in_filter;
    psum_t       psum_in_data;
    logic        psum_in_ack;
    logic        psum_out_valid;
    filter_idx_t psum_out_filter;
    psum_t       psum_out_data;
    logic        psum_out_ack = 1'b1;
    logic        conv_continue;
    logic        conv_done;
    logic        full;
    logic        error;

    // Stimulus of the current round, the model reads these
    weight_t     w [`PE_NUM_FILTERS][`PE_TAPS];
    ifdata_t     x [row_len];
    // Expected outputs in acceptance order
    filter_idx_t exp_filt_q [$];
    psum_t       exp_data_q [$];
    filter_idx_t exp_filt;
    psum_t       exp_data;
    // Output hold tracking for back-pressure
    logic        hold_pending = 1'b0;
    filter_idx_t held_filt;
    psum_t       held_data;
    int          got_cnt = 0;
    int          errors = 0;
    int          tests_failed = 0;
    int          checked = 0;
    int          errs_before;
    bit          ack_random = 1'b0;
    bit          done_check = 1'b0;

    clk_gen #(.period(100), .rst_cycles(3)) u_clk (.clk(clk), .rst_n(rst_n));

    pe_top #(.pe_idx(pe_index)) u_dut (.*);

    ////////////////////////////////////////////////////////////////////
    // Reference model and helpers
    ////////////////////////////////////////////////////////////////////

    // Window of three taps at position p, plus the upstream partial sum
    function automatic psum_t expected_psum(input int p, input int f, input psum_t pin);
        int acc = 0;
        for (int k = 0; k < `PE_TAPS; k++)
            acc += int'(w[f][k]) * int'(x[p + k]);
        acc += int'(pin);
        return psum_t'(acc);
    endfunction

    function automatic ifmap_pkt_t pack_packet(input int pk);
        ifmap_pkt_t pkt;
        for (int i = 0; i < `PE_SECT_SIZE; i++)
            pkt[i] = x[pk * `PE_SECT_SIZE + i];
        return pkt;
    endfunction

    task automatic randomize_data();
        for (int f = 0; f < `PE_NUM_FILTERS; f++)
            for (int k = 0; k < `PE_TAPS; k++)
                w[f][k] = weight_t'($urandom);
        for (int i = 0; i < row_len; i++)
            x[i] = ifdata_t'($urandom);
    endtask

    // Oldest weight first, so tap 0 ends up as the last one loaded
    task automatic load_filters(input bit foreign);
        for (int f = 0; f < `PE_NUM_FILTERS; f++) begin
            for (int k = `PE_TAPS - 1; k >= 0; k--) begin
                if (foreign) begin
                    @(posedge clk);
                    stage        <= STAGE_LOAD_FILTER;
                    filter_valid <= 1'b1;
                    filter_idx   <= 4'd6;
                    filter_sel   <= filter_idx_t'($urandom);
                    filter_data  <= weight_t'($urandom);
                end
                @(posedge clk);
                stage        <= STAGE_LOAD_FILTER;
                filter_valid <= 1'b1;
                filter_idx   <= pe_index;
                filter_sel   <= filter_idx_t'(f);
                filter_data  <= w[f][k];
            end
        end
        @(posedge clk);
        filter_valid <= 1'b0;
        stage        <= STAGE_CONV;
    endtask

    task automatic send_packets(input int n, input bit gaps, input bit foreign);
        for (int pk = 0; pk < n; pk++) begin
            if (gaps) begin
                repeat ($urandom_range(1, 12)) begin
                    @(posedge clk);
                    ifmap_valid <= 1'b0;
                end
            end
            // Packet for a neighbouring element
            if (foreign) begin
                @(posedge clk);
                ifmap_valid <= 1'b1;
                ifmap_idx   <= 4'd3;
                ifmap_data  <= ifmap_pkt_t'({$urandom});
            end
            @(posedge clk);
            ifmap_valid <= 1'b1;
            ifmap_idx   <= pe_index;
            ifmap_data  <= pack_packet(pk);
        end
        @(posedge clk);
        ifmap_valid <= 1'b0;
    endtask

    // Upstream driver, position-major and filter-minor
    task automatic send_psums();
        psum_t d;
        for (int p = 0; p < `PE_NUM_OUT; p++) begin
            for (int f = 0; f < `PE_NUM_FILTERS; f++) begin
                d = psum_t'($urandom);
                @(posedge clk);
                psum_in_valid  <= 1'b1;
                psum_in_filter <= filter_idx_t'(f);
                psum_in_data   <= d;
                @(negedge clk);
                while (!psum_in_ack)
                    @(negedge clk);
                exp_filt_q.push_back(filter_idx_t'(f));
                exp_data_q.push_back(expected_psum(p, f, d));
            end
        end
        @(posedge clk);
        psum_in_valid <= 1'b0;
    endtask

    task automatic wait_round_end();
        int  n;
        bit  finished;
        n = 0;
        @(negedge clk);
        finished = conv_done && exp_data_q.size() == 0;
        while (!finished && n < cycles_per_test) begin
            @(negedge clk);
            n++;
            finished = conv_done && exp_data_q.size() == 0;
        end
        if (!finished) begin
            $display("ERROR at %0t: round did not finish within %0d cycles", $time, n);
            errors++;
        end else if (got_cnt != round_outputs) begin
            $display("ERROR at %0t: %0d outputs seen, %0d expected", $time, got_cnt,
                     round_outputs);
            errors++;
        end
        done_check = 1'b0;
    endtask

    task automatic restart_round();
        done_check = 1'b0;
        @(posedge clk);
        conv_continue <= 1'b1;
        @(posedge clk);
        conv_continue <= 1'b0;
        got_cnt = 0;
    endtask

    task automatic run_round(input bit new_data, input bit gaps, input bit foreign,
                             input bit ack_rand);
        if (new_data)
            randomize_data();
        load_filters(foreign);
        ack_random = ack_rand;
        done_check = !ack_rand;
        fork
            send_packets(`PE_NUM_SECT, gaps, foreign);
            send_psums();
        join
        wait_round_end();
        ack_random = 1'b0;
    endtask

    task automatic report_test(input int num, input string name);
        if (errors == errs_before) begin
            $display("test %0d %s: pass", num, name);
        end else begin
            $display("test %0d %s: fail, %0d errors", num, name, errors - errs_before);
            tests_failed++;
        end
        errs_before = errors;
    endtask

    ////////////////////////////////////////////////////////////////////
    // Output side: consumer ack and compare
    ////////////////////////////////////////////////////////////////////

    always @(posedge clk)
        psum_out_ack <= ack_random ? ($urandom % 2 == 0) : 1'b1;

    always @(negedge clk) begin
        if (rst_n) begin
            // Held data must not move before it is taken
            if (hold_pending && (!psum_out_valid || psum_out_data != held_data
                                 || psum_out_filter != held_filt)) begin
                $display("MISMATCH at %0t: psum_out changed while unacknowledged", $time);
                errors++;
            end
            hold_pending = psum_out_valid && !psum_out_ack;
            held_data    = psum_out_data;
            held_filt    = psum_out_filter;
            if (psum_out_valid && psum_out_ack) begin
                got_cnt++;
                if (exp_data_q.size() == 0) begin
                    $display("ERROR at %0t: output with no partial sum sent for it", $time);
                    errors++;
                end else begin
                    exp_filt = exp_filt_q.pop_front();
                    exp_data = exp_data_q.pop_front();
                    checked++;
                    if (psum_out_filter != exp_filt || psum_out_data != exp_data) begin
                        $display("MISMATCH at %0t: got filter %0d data %0d, expected %0d %0d",
                                 $time, psum_out_filter, psum_out_data, exp_filt, exp_data);
                        errors++;
                    end
                end
            end
            if (done_check && conv_done && got_cnt < round_outputs) begin
                $display("ERROR at %0t: conv_done rose after %0d outputs", $time, got_cnt);
                errors++;
                done_check = 1'b0;
            end
        end
    end

    // Watchdog sized from the test count
    initial begin
        repeat (num_tests * cycles_per_test) @(posedge clk);
        $display("ERROR at %0t: run timed out", $time);
        $display("*** FAILED ***");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////

    initial begin
        void'($urandom(32'h4e5148e0));
        stage          <= STAGE_IDLE;
        filter_valid   <= 1'b0;
        filter_sel     <= '0;
        filter_idx     <= '0;
        filter_data    <= '0;
        ifmap_valid    <= 1'b0;
        ifmap_idx      <= '0;
        ifmap_data     <= '0;
        psum_in_valid  <= 1'b0;
        psum_in_filter <= '0;
        psum_in_data   <= '0;
        conv_continue  <= 1'b0;
        errs_before    = 0;
        wait (rst_n);
        @(posedge clk);

        run_round(1'b1, 1'b0, 1'b0, 1'b0);
        report_test(1, "basic round");

        // Same weights and row, packets trickle in
        restart_round();
        run_round(1'b0, 1'b1, 1'b0, 1'b0);
        report_test(2, "starved input");

        restart_round();
        run_round(1'b1, 1'b0, 1'b0, 1'b1);
        report_test(3, "back-pressure");

        // Slots fill with no upstream data, pipeline freezes
        restart_round();
        randomize_data();
        load_filters(1'b0);
        done_check = 1'b1;
        send_packets(`PE_NUM_SECT, 1'b0, 1'b0);
        @(negedge clk);
        if (!full) begin
            $display("ERROR at %0t: full is low after three packets", $time);
            errors++;
        end
        repeat (40) @(posedge clk);
        ifmap_valid <= 1'b1;
        ifmap_idx   <= pe_index;
        ifmap_data  <= ifmap_pkt_t'({$urandom});
        @(negedge clk);
        if (!error) begin
            $display("ERROR at %0t: fourth packet into a full scratchpad gave no error", $time);
            errors++;
        end
        @(posedge clk);
        ifmap_valid <= 1'b0;
        send_psums();
        wait_round_end();
        report_test(4, "overflow");

        // Foreign traffic, then a restart into a fresh round
        restart_round();
        run_round(1'b1, 1'b0, 1'b1, 1'b0);
        restart_round();
        @(negedge clk);
        if (conv_done) begin
            $display("ERROR at %0t: conv_done still high after conv_continue", $time);
            errors++;
        end
        run_round(1'b1, 1'b1, 1'b1, 1'b0);
        report_test(5, "filtering and restart");

        $display("tests %0d, failed %0d, outputs checked %0d, errors %0d",
                 num_tests, tests_failed, checked, errors);
        if (errors == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== pe_top.f ====
+incdir+hdl
hdl/pe_pkg.sv
hdl/mac_if.sv
hdl/pe_ctrl.sv
hdl/filter_spad.sv
hdl/ifmap_spad.sv
hdl/mac_pipe.sv
hdl/psum_out_buf.sv
hdl/pe_top.sv
bench/clk_gen.sv
bench/pe_tb.sv
